// File: verilog/gb_cart_pkg.sv
// --------------------
// shared constants for the cartridge side of the handheld core
// header offsets, cpu region codes, bus widths, cart address union
// --------------------

package gb_cart_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int CART_ADDR_W = 16;                      // cpu cart bus
	localparam int ROM_BANK_W  = 9;                       // mbc5 has 512 banks max
	localparam int ROM_OFFS_W  = 14;                      // 16k rom bank
	localparam int ROM_ADDR_W  = ROM_BANK_W + ROM_OFFS_W; // 8MB byte address
	localparam int CRAM_OFFS_W = 13;                      // 8k ram bank
	localparam int DL_ADDR_W   = 25;                      // download port byte address

	// --------------------
	// header fields
	// --------------------
	// the download port moves 16-bit words at even addresses,
	// the high byte is the odd address
	localparam logic [DL_ADDR_W-1:0] HDR_CGB_ADDR  = 25'h000142; // cgb flag in high byte (143h)
	localparam logic [DL_ADDR_W-1:0] HDR_TYPE_ADDR = 25'h000146; // mapper type in high byte (147h)
	localparam logic [DL_ADDR_W-1:0] HDR_SIZE_ADDR = 25'h000148; // rom size low, ram size high

	// --------------------
	// cpu write/read regions, cart_addr[15:13]
	// --------------------
	localparam logic [2:0] REGION_RAM_EN   = 3'b000; // 0000-1fff
	localparam logic [2:0] REGION_ROM_BANK = 3'b001; // 2000-3fff
	localparam logic [2:0] REGION_RAM_BANK = 3'b010; // 4000-5fff
	localparam logic [2:0] REGION_MODE     = 3'b011; // 6000-7fff
	localparam logic [2:0] REGION_CRAM     = 3'b101; // a000-bfff

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA; // low nibble that opens cart ram

	// one cpu address word, seen two ways
	typedef struct packed {
		logic [2:0]             region; // 8k region code
		logic [CRAM_OFFS_W-1:0] offs;   // offset inside an 8k ram bank
	} cart_rgn_view_t;

	typedef struct packed {
		logic [1:0]            quad; // 16k quadrant, 0 fixed bank, 1 switchable
		logic [ROM_OFFS_W-1:0] offs; // offset inside a 16k rom bank
	} cart_rom_view_t;

	typedef union packed {
		cart_rgn_view_t rgn;
		cart_rom_view_t rom;
	} cart_addr_u;

endpackage

// File: verilog/cart_header_capture.sv
// --------------------
// snoops the rom download stream for the cartridge header bytes
// decodes mapper kind and bank masks, flags when the cart is ready
// --------------------
`timescale 1ns/1ps

module cart_header_capture #(
	parameter int CRAM_BANK_W = 4
) (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             cart_download, // high for whole image
	input  logic                             dl_wr,         // one strobe per word
	input  logic [gb_cart_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [15:0]                      dl_data,
	output logic                             is_mbc1,
	output logic                             is_mbc2,
	output logic                             is_mbc3,
	output logic                             is_mbc5,
	output logic [gb_cart_pkg::ROM_BANK_W-1:0] rom_mask,
	output logic [CRAM_BANK_W-1:0]           ram_mask,
	output logic                             cart_ready,
	output logic                             is_gbc_game
);
	import gb_cart_pkg::*;

	logic [7:0] cart_type;
	logic [7:0] rom_size;
	logic [7:0] ram_size;
	logic [7:0] cgb_flag;
	logic       download_q; // delayed level for falling edge
	logic [ROM_BANK_W:0] rom_span; // bank count, one bit wider

	// --------------------
	// header capture
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
			cgb_flag  <= 8'h00;
		end else if (cart_download && dl_wr) begin
			if (dl_addr == HDR_CGB_ADDR)  cgb_flag  <= dl_data[15:8];
			if (dl_addr == HDR_TYPE_ADDR) cart_type <= dl_data[15:8];
			if (dl_addr == HDR_SIZE_ADDR) begin
				rom_size <= dl_data[7:0];
				ram_size <= dl_data[15:8];
			end
		end
	end

	// ready one cycle after download ends, dropped when the next one starts
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			cart_ready <= 1'b0;
		end else begin
			download_q <= cart_download;
			if (cart_download)
				cart_ready <= 1'b0;
			else if (download_q)
				cart_ready <= 1'b1; // falling edge of cart_download
		end
	end

	// mapper kind from the type byte
	assign is_mbc1 = (cart_type >= 8'd1)  && (cart_type <= 8'd3);
	assign is_mbc2 = (cart_type == 8'd5)  || (cart_type == 8'd6);
	assign is_mbc3 = (cart_type >= 8'd15) && (cart_type <= 8'd19);
	assign is_mbc5 = (cart_type >= 8'd25) && (cart_type <= 8'd30);

	// size 0 is 2 banks, each step doubles; odd sizes 52h-54h fall back to 128 banks
	assign rom_span = (ROM_BANK_W+1)'(2) << rom_size[3:0];
	assign rom_mask = (rom_size <= 8'd8) ? rom_span[ROM_BANK_W-1:0] - 1'b1 :
		ROM_BANK_W'(8'h7F);

	always_comb begin
		if (ram_size <= 8'd2)
			ram_mask = '0;                 // none, 2k or 8k, single bank
		else if (ram_size == 8'd3)
			ram_mask = CRAM_BANK_W'(2'b11); // 32k, 4 banks
		else
			ram_mask = '1;                 // 128k and up
	end

	assign is_gbc_game = (cgb_flag == 8'h80) || (cgb_flag == 8'hC0);

	// the type tables must never overlap, bank regs and map rely on it
	a_one_kind: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({is_mbc1, is_mbc2, is_mbc3, is_mbc5}));

endmodule

// File: verilog/mbc_bank_regs.sv
// --------------------
// mapper control registers, written by cpu stores to 0000-7fff
// held at defaults while in reset or while a new image downloads
// --------------------
`timescale 1ns/1ps

module mbc_bank_regs (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               cart_download,
	input  logic [gb_cart_pkg::CART_ADDR_W-1:0] cart_addr,
	input  logic                               cart_wr,  // one cycle store strobe
	input  logic [7:0]                         cart_di,
	input  logic                               is_mbc1,
	input  logic                               is_mbc3,
	input  logic                               is_mbc5,
	output logic [gb_cart_pkg::ROM_BANK_W-1:0] rom_bank_reg,
	output logic [3:0]                         ram_bank_reg, // 0-15
	output logic                               mbc1_mode,     // 0 = 16/8, 1 = 4/32
	output logic                               mbc3_rtc_mode, // a000-bfff shows rtc
	output logic                               ram_enable
);
	import gb_cart_pkg::*;

	cart_addr_u wr_addr;

	assign wr_addr = cart_addr;

	// --------------------
	// register writes
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset || cart_download) begin
			rom_bank_reg  <= ROM_BANK_W'(1); // bank 1 in 4000-7fff
			ram_bank_reg  <= 4'd0;
			mbc1_mode     <= 1'b0;
			mbc3_rtc_mode <= 1'b0;
			ram_enable    <= 1'b0;
		end else if (cart_wr) begin
			case (wr_addr.rgn.region)
				REGION_RAM_EN: begin
					// any other value locks the ram again
					ram_enable <= (cart_di[3:0] == RAM_ENABLE_KEY);
				end

				REGION_ROM_BANK: begin
					if (is_mbc5) begin
						if (wr_addr.rgn.offs[CRAM_OFFS_W-1])
							rom_bank_reg[ROM_BANK_W-1] <= cart_di[0]; // 3000-3fff, bit 8
						else
							rom_bank_reg[ROM_BANK_W-2:0] <= cart_di;  // 2000-2fff, low byte
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank_reg <= ROM_BANK_W'(1); // mbc1-3 can't select bank 0 here
					end else begin
						rom_bank_reg <= ROM_BANK_W'(cart_di[6:0]);
					end
				end

				REGION_RAM_BANK: begin
					if (is_mbc3) begin
						if (cart_di[3]) begin
							mbc3_rtc_mode <= 1'b1; // 08h-0ch pick an rtc register
						end else begin
							mbc3_rtc_mode <= 1'b0;
							ram_bank_reg  <= {2'b00, cart_di[1:0]};
						end
					end else if (is_mbc5) begin
						ram_bank_reg <= cart_di[3:0]; // 16 banks
					end else begin
						// mbc1, also upper rom bits in mode 0
						ram_bank_reg <= {2'b00, cart_di[1:0]};
					end
				end

				REGION_MODE: begin
					if (is_mbc1)
						mbc1_mode <= cart_di[0];
				end

				default: ; // other regions are not registers
			endcase
		end
	end

	// bank 0 in the switchable window is an mbc5 feature only
	a_bank_not_zero: assert property (@(posedge clk_sys) disable iff (reset || cart_download)
		!is_mbc5 |-> (rom_bank_reg != '0));

endmodule

// File: verilog/mbc_addr_map.sv
// --------------------
// cpu address to external rom byte address and cart ram address
// purely combinational, banks masked to the sizes from the header
// --------------------
`timescale 1ns/1ps

module mbc_addr_map #(
	parameter int CRAM_BANK_W = 4
) (
	input  logic [gb_cart_pkg::CART_ADDR_W-1:0] cart_addr,
	input  logic [gb_cart_pkg::ROM_BANK_W-1:0]  rom_bank_reg,
	input  logic [3:0]                          ram_bank_reg,
	input  logic                                mbc1_mode,
	input  logic                                is_mbc1,
	input  logic                                is_mbc2,
	input  logic                                is_mbc3,
	input  logic                                is_mbc5,
	input  logic [gb_cart_pkg::ROM_BANK_W-1:0]  rom_mask,
	input  logic [CRAM_BANK_W-1:0]              ram_mask,
	output logic [gb_cart_pkg::ROM_ADDR_W-1:0]  rom_addr,
	output logic [CRAM_BANK_W+gb_cart_pkg::CRAM_OFFS_W-1:0] cram_addr
);
	import gb_cart_pkg::*;

	cart_addr_u                a;
	logic                      has_mapper;
	logic [ROM_BANK_W-1:0]     mbc_bank;  // selected bank before masking
	logic [ROM_BANK_W-1:0]     rom_bank;
	logic [CRAM_BANK_W-1:0]    ram_bank_m;
	logic [CRAM_BANK_W-1:0]    cram_bank;

	assign a          = cart_addr;
	assign has_mapper = is_mbc1 | is_mbc2 | is_mbc3 | is_mbc5;

	// --------------------
	// rom banking
	// --------------------
	always_comb begin
		if (is_mbc1)
			// mode 0: ram bank bits are rom lines 5-6
			mbc_bank = ROM_BANK_W'({mbc1_mode ? 2'b00 : ram_bank_reg[1:0],
				rom_bank_reg[4:0]});
		else if (is_mbc5)
			mbc_bank = rom_bank_reg; // full 9 bits, bank 0 allowed
		else
			mbc_bank = ROM_BANK_W'(rom_bank_reg[6:0]); // mbc2, mbc3
	end

	always_comb begin
		case (a.rom.quad)
			2'b00:   rom_bank = '0;                      // 0000-3fff fixed bank
			2'b01:   rom_bank = has_mapper ? (mbc_bank & rom_mask) :
				ROM_BANK_W'(1);                          // 32k linear without mapper
			default: rom_bank = '0;                      // not a rom window
		endcase
	end

	assign rom_addr = {rom_bank, a.rom.offs};

	// --------------------
	// cart ram banking
	// --------------------
	// mask folds banks beyond the header ram size back onto real storage
	assign ram_bank_m = ram_bank_reg[CRAM_BANK_W-1:0] & ram_mask;

	always_comb begin
		if (is_mbc1)
			cram_bank = mbc1_mode ? ram_bank_m : '0; // mode 0 has one ram bank
		else if (is_mbc3 || is_mbc5)
			cram_bank = ram_bank_m;
		else
			cram_bank = '0; // mbc2 and plain carts
	end

	assign cram_addr = {cram_bank, a.rgn.offs};

endmodule

// File: verilog/cart_read_port.sv
// --------------------
// cart ram storage and the cpu read path
// ram or rom byte is picked at the read edge and held on cart_do
// --------------------
`timescale 1ns/1ps

module cart_read_port #(
	parameter int CRAM_BANK_W = 4
) (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic [gb_cart_pkg::CART_ADDR_W-1:0] cart_addr,
	input  logic                               cart_rd,
	input  logic                               cart_wr,
	input  logic [7:0]                         cart_di,
	input  logic [CRAM_BANK_W+gb_cart_pkg::CRAM_OFFS_W-1:0] cram_addr,
	input  logic [7:0]                         rom_q,     // valid same cycle as rom_addr
	input  logic                               ram_enable,
	input  logic                               mbc3_rtc_mode,
	input  logic                               is_mbc2,
	input  logic                               cart_ready,
	output logic                               rom_rd,
	output logic [7:0]                         cart_do
);
	import gb_cart_pkg::*;

	localparam int CRAM_DEPTH = 2 ** (CRAM_BANK_W + CRAM_OFFS_W); // 128k at 4 bank bits

	cart_addr_u a;
	logic       is_cram;   // a000-bfff
	logic       mbc2_win;  // a000-a1ff, 512 x 4 bit on mbc2
	logic       cram_rd;
	logic       cram_wr;

	logic [7:0] cram_mem [CRAM_DEPTH];
	logic [7:0] cram_q;    // registered ram byte

	logic       rd_from_ram; // last read returns stored data
	logic       rd_nibble;   // ... with the mbc2 top nibble forced
	logic [7:0] rd_byte;     // rom byte or fixed ffh/00h

	assign a        = cart_addr;
	assign is_cram  = (a.rgn.region == REGION_CRAM);
	assign mbc2_win = (a.rgn.offs[CRAM_OFFS_W-1:9] == '0);
	assign cram_rd  = cart_rd & is_cram;
	assign cram_wr  = cart_wr & is_cram;

	// external rom is only touched outside the cram window
	assign rom_rd = cart_rd & ~is_cram;

	// --------------------
	// cart ram array
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (cram_wr)
			cram_mem[cram_addr] <= cart_di;
		if (cram_rd)
			cram_q <= cram_mem[cram_addr]; // sync read, block ram friendly
	end

	// --------------------
	// read source, captured at the cart_rd edge
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_from_ram <= 1'b0;
			rd_nibble   <= 1'b0;
			rd_byte     <= 8'h00;
		end else if (cart_rd) begin
			rd_from_ram <= is_cram & ram_enable & ~mbc3_rtc_mode;
			rd_nibble   <= is_mbc2 & mbc2_win;
			if (!is_cram)
				rd_byte <= rom_q;
			else if (!ram_enable)
				rd_byte <= 8'hFF; // ram locked, bus floats high
			else
				rd_byte <= 8'h00; // rtc registers not modelled
		end
	end

	// nothing comes out of the cart until the image is in
	always_comb begin
		if (!cart_ready)
			cart_do = 8'h00;
		else if (!rd_from_ram)
			cart_do = rd_byte;
		else if (rd_nibble)
			cart_do = {4'hF, cram_q[3:0]}; // mbc2 ram is 4 bits wide
		else
			cart_do = cram_q;
	end

	// cpu bus issues one access per cycle, the ram port depends on it
	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(cart_rd && cart_wr));

endmodule

// File: verilog/gb_cart_top.sv
// --------------------
// cartridge side of the console core
// header snoop, mapper registers, address map and read port
// --------------------
`timescale 1ns/1ps

module gb_cart_top #(
	parameter int CRAM_BANK_W = 4 // 16 ram banks, 128k
) (
	input  logic                               clk_sys,
	input  logic                               reset,
	// rom image download
	input  logic                               cart_download,
	input  logic                               dl_wr,
	input  logic [gb_cart_pkg::DL_ADDR_W-1:0]  dl_addr,
	input  logic [15:0]                        dl_data,
	// cpu cart bus
	input  logic [gb_cart_pkg::CART_ADDR_W-1:0] cart_addr,
	input  logic                               cart_rd,
	input  logic                               cart_wr,
	input  logic [7:0]                         cart_di,
	output logic [7:0]                         cart_do,
	// external rom, byte wide
	output logic [gb_cart_pkg::ROM_ADDR_W-1:0] rom_addr,
	output logic                               rom_rd,
	input  logic [7:0]                         rom_q,
	// status
	output logic                               cart_ready,
	output logic                               is_gbc_game
);
	import gb_cart_pkg::*;

	logic                              is_mbc1, is_mbc2, is_mbc3, is_mbc5;
	logic [ROM_BANK_W-1:0]             rom_mask;
	logic [CRAM_BANK_W-1:0]            ram_mask;
	logic [ROM_BANK_W-1:0]             rom_bank_reg;
	logic [3:0]                        ram_bank_reg;
	logic                              mbc1_mode, mbc3_rtc_mode, ram_enable;
	logic [CRAM_BANK_W+CRAM_OFFS_W-1:0] cram_addr;

	cart_header_capture #(.CRAM_BANK_W(CRAM_BANK_W)) cart_header_capture_inst (
		.clk_sys, .reset, .cart_download, .dl_wr, .dl_addr, .dl_data,
		.is_mbc1, .is_mbc2, .is_mbc3, .is_mbc5,
		.rom_mask, .ram_mask, .cart_ready, .is_gbc_game
	);

	mbc_bank_regs mbc_bank_regs_inst (
		.clk_sys, .reset, .cart_download, .cart_addr, .cart_wr, .cart_di,
		.is_mbc1, .is_mbc3, .is_mbc5,
		.rom_bank_reg, .ram_bank_reg, .mbc1_mode, .mbc3_rtc_mode, .ram_enable
	);

	mbc_addr_map #(.CRAM_BANK_W(CRAM_BANK_W)) mbc_addr_map_inst (
		.cart_addr, .rom_bank_reg, .ram_bank_reg, .mbc1_mode,
		.is_mbc1, .is_mbc2, .is_mbc3, .is_mbc5,
		.rom_mask, .ram_mask, .rom_addr, .cram_addr
	);

	cart_read_port #(.CRAM_BANK_W(CRAM_BANK_W)) cart_read_port_inst (
		.clk_sys, .reset, .cart_addr, .cart_rd, .cart_wr, .cart_di,
		.cram_addr, .rom_q, .ram_enable, .mbc3_rtc_mode, .is_mbc2,
		.cart_ready, .rom_rd, .cart_do
	);

endmodule

// File: verif/gb_cart_tb.sv
// --------------------
// self-checking testbench for the cartridge core
// walks a table of header downloads, cart writes and cart reads
// --------------------
`timescale 1ns/1ps

module gb_cart_tb;

	localparam logic [1:0] OP_HDR = 2'd0; // addr holds cgb flag and type, data holds both sizes
	localparam logic [1:0] OP_WR  = 2'd1;
	localparam logic [1:0] OP_RD  = 2'd2; // exp is the rom bank or the a000-bfff byte

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        cart_download;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic [15:0] cart_addr;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_di;
	logic [7:0]  cart_do;
	logic [22:0] rom_addr;
	logic        rom_rd;
	logic [7:0]  rom_q;
	logic        cart_ready;
	logic        is_gbc_game;

	logic [1:0]  row_op   [$]; // stimulus table with one entry per row
	logic [15:0] row_addr [$];
	logic [15:0] row_data [$];
	logic [15:0] row_exp  [$];
	integer      seed = 32'he849;
	int          cycle_cnt = 0;
	int          cycle_limit;
	int          i;

	always #20 clk_sys = ~clk_sys; // 40 ns

	// rom model folds the byte address into a byte
	assign rom_q = rom_addr[7:0] ^ rom_addr[15:8];

	gb_cart_top #(.CRAM_BANK_W(4)) gb_cart_top_inst (.*);

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout, the table did not finish within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	function automatic logic [7:0] rom_model(input logic [22:0] a);
		return a[7:0] ^ a[15:8];
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error: time %0t %s got %0h expected %0h", $time, name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic add_row(input logic [1:0] op, input logic [15:0] a,
		input logic [15:0] d, input logic [15:0] e);
		row_op.push_back(op);
		row_addr.push_back(a);
		row_data.push_back(d);
		row_exp.push_back(e);
	endtask

	// --------------------
	// bus tasks
	// --------------------
	task automatic download_header(input logic [7:0] cgb, input logic [7:0] ctype,
		input logic [15:0] sizes, input logic gbc_exp);
		logic [24:0] a;
		logic [15:0] w;
		int          k;
		int          waited;
		@(posedge clk_sys);
		cart_download <= 1'b1;
		for (k = 0; k < 8; k++) begin // words 140h-14eh
			a = 25'h140 + 25'(2 * k);
			w = 16'($random(seed)); // filler around the header fields
			if (a == 25'h142)
				w[15:8] = cgb;
			if (a == 25'h146)
				w[15:8] = ctype;
			if (a == 25'h148)
				w = sizes;
			@(posedge clk_sys);
			dl_addr <= a;
			dl_data <= w;
			dl_wr   <= 1'b1;
		end
		// a read while the image is still loading gives 0
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		cart_addr <= 16'h0150;
		cart_rd   <= 1'b1;
		@(posedge clk_sys);
		cart_rd <= 1'b0;
		@(negedge clk_sys);
		compare("cart_do", cart_do, 0);
		compare("cart_ready", cart_ready, 0);
		@(posedge clk_sys);
		cart_download <= 1'b0;
		waited = 0;
		@(negedge clk_sys);
		while (!cart_ready) begin // wait for the ready flag
			waited++;
			@(negedge clk_sys);
		end
		compare("cart_ready delay", waited, 1); // one cycle after the fall
		compare("is_gbc_game", is_gbc_game, gbc_exp);
	endtask

	task automatic cart_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cart_addr <= a;
		cart_di   <= d;
		cart_wr   <= 1'b1;
		@(posedge clk_sys);
		cart_wr <= 1'b0;
	endtask

	task automatic cart_read(input logic [15:0] a, input logic [15:0] e);
		logic        in_cram;
		logic [22:0] exp_addr;
		logic [7:0]  exp_byte;
		in_cram  = (a[15:13] == 3'b101);
		exp_addr = {e[8:0], a[13:0]}; // table bank above the cpu offset
		exp_byte = in_cram ? e[7:0] : rom_model(exp_addr);
		@(posedge clk_sys);
		cart_addr <= a;
		cart_rd   <= 1'b1;
		@(negedge clk_sys); // rom side is combinational
		compare("rom_rd", rom_rd, !in_cram);
		if (!in_cram)
			compare("rom_addr", rom_addr, exp_addr);
		@(posedge clk_sys);
		cart_rd <= 1'b0;
		@(negedge clk_sys);
		compare("cart_do", cart_do, exp_byte);
		compare("rom_rd", rom_rd, 0); // strobe drops with cart_rd
	endtask

	initial begin
		logic [15:0] a;
		logic [15:0] d;
		logic [15:0] e;
		reset         <= 1'b1;
		cart_download <= 1'b0;
		dl_wr         <= 1'b0;
		dl_addr       <= '0;
		dl_data       <= '0;
		cart_addr     <= '0;
		cart_rd       <= 1'b0;
		cart_wr       <= 1'b0;
		cart_di       <= '0;

		// --------------------
		// stimulus table
		// --------------------
		add_row(OP_HDR, 16'h8000, 16'h0000, 16'h1);   // no mapper on a cgb game
		add_row(OP_RD,  16'h4123, 16'h0000, 16'h001); // linear 32k
		add_row(OP_RD,  16'h0155, 16'h0000, 16'h000);
		add_row(OP_WR,  16'h2000, 16'h0005, 16'h000); // ignored without mapper
		add_row(OP_RD,  16'h7ABC, 16'h0000, 16'h001);
		add_row(OP_HDR, 16'h0001, 16'h0305, 16'h0);   // mbc1 with 64 banks and 32k ram
		add_row(OP_WR,  16'h2000, 16'h0000, 16'h000); // 0 turns into 1
		add_row(OP_RD,  16'h4000, 16'h0000, 16'h001);
		add_row(OP_WR,  16'h2100, 16'h0013, 16'h000);
		add_row(OP_WR,  16'h4000, 16'h0001, 16'h000); // upper rom bits in mode 0
		add_row(OP_RD,  16'h6001, 16'h0000, 16'h033);
		add_row(OP_WR,  16'h4000, 16'h0003, 16'h000); // 73h wraps to 33h
		add_row(OP_RD,  16'h6002, 16'h0000, 16'h033);
		add_row(OP_WR,  16'h6000, 16'h0001, 16'h000); // mode 1
		add_row(OP_RD,  16'h4ABC, 16'h0000, 16'h013);
		add_row(OP_HDR, 16'hC019, 16'h0408, 16'h1);   // mbc5 with 512 banks and 128k ram
		add_row(OP_WR,  16'h2000, 16'h0000, 16'h000);
		add_row(OP_RD,  16'h4444, 16'h0000, 16'h000); // bank 0 in 4000-7fff
		add_row(OP_WR,  16'h3000, 16'h0001, 16'h000);
		add_row(OP_WR,  16'h2FFF, 16'h005A, 16'h000);
		add_row(OP_RD,  16'h7FFF, 16'h0000, 16'h15A);
		add_row(OP_WR,  16'h0000, 16'h000A, 16'h000);
		add_row(OP_WR,  16'h4000, 16'h0000, 16'h000);
		add_row(OP_WR,  16'hA100, 16'h0011, 16'h000);
		add_row(OP_WR,  16'h4000, 16'h0008, 16'h000); // only bank bit 3 set
		add_row(OP_WR,  16'hA100, 16'h0099, 16'h000);
		add_row(OP_RD,  16'hA100, 16'h0000, 16'h099);
		add_row(OP_WR,  16'h4000, 16'h0000, 16'h000);
		add_row(OP_RD,  16'hA100, 16'h0000, 16'h011);
		add_row(OP_HDR, 16'h401B, 16'h0302, 16'h0);   // mbc5 with 32k ram
		add_row(OP_RD,  16'hA000, 16'h0000, 16'h0FF); // ram still locked
		add_row(OP_WR,  16'h0000, 16'h000A, 16'h000);
		add_row(OP_WR,  16'h4000, 16'h0001, 16'h000);
		add_row(OP_WR,  16'hA000, 16'h003C, 16'h000);
		add_row(OP_RD,  16'hA000, 16'h0000, 16'h03C);
		add_row(OP_WR,  16'h4000, 16'h0005, 16'h000); // aliases bank 1
		add_row(OP_RD,  16'hA000, 16'h0000, 16'h03C);
		add_row(OP_WR,  16'h0000, 16'h0000, 16'h000);
		add_row(OP_RD,  16'hA000, 16'h0000, 16'h0FF);
		add_row(OP_WR,  16'h1FFF, 16'h001A, 16'h000); // only the low nibble counts
		add_row(OP_RD,  16'hA000, 16'h0000, 16'h03C);
		add_row(OP_HDR, 16'h0005, 16'h0003, 16'h0);   // mbc2 with 16 banks
		add_row(OP_WR,  16'h0000, 16'h000A, 16'h000);
		add_row(OP_WR,  16'hA005, 16'h005B, 16'h000);
		add_row(OP_RD,  16'hA005, 16'h0000, 16'h0FB); // 4 bit ram
		add_row(OP_WR,  16'hA200, 16'h0032, 16'h000);
		add_row(OP_RD,  16'hA200, 16'h0000, 16'h032);
		add_row(OP_WR,  16'h2000, 16'h0013, 16'h000);
		add_row(OP_RD,  16'h4ABC, 16'h0000, 16'h003);
		add_row(OP_HDR, 16'hC013, 16'h0306, 16'h1);   // mbc3 with 32k ram
		add_row(OP_WR,  16'h0000, 16'h000A, 16'h000);
		add_row(OP_WR,  16'h4000, 16'h0002, 16'h000);
		add_row(OP_WR,  16'hA020, 16'h006D, 16'h000);
		add_row(OP_RD,  16'hA020, 16'h0000, 16'h06D);
		add_row(OP_WR,  16'h4000, 16'h0008, 16'h000); // rtc register select
		add_row(OP_RD,  16'hA020, 16'h0000, 16'h000);
		add_row(OP_WR,  16'h4000, 16'h0002, 16'h000);
		add_row(OP_RD,  16'hA020, 16'h0000, 16'h06D);
		cycle_limit = row_op.size() * 4 + 200;

		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		for (i = 0; i < row_op.size(); i++) begin
			a = row_addr[i];
			d = row_data[i];
			e = row_exp[i];
			case (row_op[i])
				OP_HDR:  download_header(a[15:8], a[7:0], d, e[0]);
				OP_WR:   cart_write(a, d[7:0]);
				default: cart_read(a, e);
			endcase
		end
		@(posedge clk_sys);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: sources.f
verilog/gb_cart_pkg.sv
verilog/cart_header_capture.sv
verilog/mbc_bank_regs.sv
verilog/mbc_addr_map.sv
verilog/cart_read_port.sv
verilog/gb_cart_top.sv
verif/gb_cart_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cartridge testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module gb_cart_tb \
	-f sources.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vgb_cart_tb > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
